// ==== logic/busMapPkg.sv ====
`default_nettype none

package busMapPkg;

    //**************************************************
    // Bus widths
    //**************************************************
    localparam int BUS_ADDR_WIDTH = 4;
    localparam int BUS_DATA_WIDTH = 16;

    localparam logic [BUS_DATA_WIDTH-1:0] VERSION_NUMBER = 16'd624;

    //**************************************************
    // Register map
    //**************************************************
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_VERSION       = 4'd0;  // Read only
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_DAC0_SOURCE   = 4'd1;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_DAC1_SOURCE   = 4'd2;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_TEST_VALUE    = 4'd3;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_SAMPLE_PERIOD = 4'd4;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_DROP_COUNT    = 4'd5;  // Read only

endpackage

`default_nettype wire

// ==== logic/sampleStreamPkg.sv ====
`default_nettype none

package sampleStreamPkg;

    localparam int ADC_WIDTH    = 14;  // Offset binary from the converter
    localparam int SAMPLE_WIDTH = 18;
    localparam int DAC_WIDTH    = 14;
    localparam int SAMPLE_PAD   = SAMPLE_WIDTH - ADC_WIDTH;  // Zero LSBs below the ADC word

    localparam logic [DAC_WIDTH-1:0] DAC_MID_SCALE = 14'd8192;

    // Buffer sizing
    localparam int FIFO_DEPTH       = 8;
    localparam int FIFO_PTR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // DAC source select where code 3 mutes as well
    typedef logic [1:0] dacSource_t;
    localparam dacSource_t SRC_ADC  = 2'd0;
    localparam dacSource_t SRC_TEST = 2'd1;
    localparam dacSource_t SRC_MUTE = 2'd2;

endpackage

`default_nettype wire

// ==== logic/sampleStreamIf.sv ====
`default_nettype none

// Valid/ready sample stream with a transfer when both are high at a clock edge
interface sampleStreamIf;

    logic                     valid;
    logic                     ready;
    sampleStreamPkg::sample_t sample;
    logic                     overRange;  // Rides along with each sample

    modport source (
        output valid, sample, overRange,
        input  ready
    );

    modport sink (
        input  valid, sample, overRange,
        output ready
    );

endinterface

`default_nettype wire

// ==== logic/dacControlIf.sv ====
`default_nettype none

// Register settings for the DAC formatter
interface dacControlIf;

    sampleStreamPkg::dacSource_t           dac0Source;
    sampleStreamPkg::dacSource_t           dac1Source;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] testValue;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] samplePeriod;  // Clocks per output slot

    modport regs (
        output dac0Source, dac1Source, testValue, samplePeriod
    );

    modport user (
        input  dac0Source, dac1Source, testValue, samplePeriod
    );

endinterface

`default_nettype wire

// ==== logic/adcCapture.sv ====
`default_nettype none

module adcCapture (
    input  wire logic                                   clk,
    input  wire logic                                   rstN,
    input  wire logic [sampleStreamPkg::ADC_WIDTH-1:0] adc,
    input  wire logic                                   adcOverflow,
    input  wire logic                                   adcEn,
    sampleStreamIf.source                               out,
    output logic [busMapPkg::BUS_DATA_WIDTH-1:0]        dropCount
);

    logic [sampleStreamPkg::ADC_WIDTH-1:0] adcReg;
    logic                                  overflowReg;
    logic                                  enReg;

    //**************************************************
    // Reclock the converter pins
    //**************************************************
    always_ff @(posedge clk) begin
        if (adcEn) begin
            adcReg      <= adc;
            overflowReg <= adcOverflow;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            enReg     <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            enReg     <= adcEn;
            out.valid <= enReg;  // One cycle pulse per captured word
        end
    end

    // Offset binary to left justified two's complement
    always_ff @(posedge clk) begin
        out.sample <= $signed({~adcReg[sampleStreamPkg::ADC_WIDTH-1],
                               adcReg[sampleStreamPkg::ADC_WIDTH-2:0],
                               {sampleStreamPkg::SAMPLE_PAD{1'b0}}});
        out.overRange <= overflowReg;
    end

    // Sample is lost when the buffer is full at the pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dropCount <= '0;
        end else if (out.valid && !out.ready && (dropCount != '1)) begin
            dropCount <= dropCount + 1'b1;  // Saturates
        end
    end

endmodule

`default_nettype wire

// ==== logic/sampleFifo.sv ====
`default_nettype none

module sampleFifo (
    input  wire logic clk,
    input  wire logic rstN,
    sampleStreamIf.sink   in,
    sampleStreamIf.source out
);

    sampleStreamPkg::sample_t sampleMem [sampleStreamPkg::FIFO_DEPTH];
    logic                     flagMem   [sampleStreamPkg::FIFO_DEPTH];

    logic [sampleStreamPkg::FIFO_PTR_WIDTH-1:0]   wrPtr;
    logic [sampleStreamPkg::FIFO_PTR_WIDTH-1:0]   rdPtr;
    logic [sampleStreamPkg::FIFO_COUNT_WIDTH-1:0] count;
    logic                                         push;
    logic                                         pop;

    localparam logic [sampleStreamPkg::FIFO_PTR_WIDTH-1:0] LAST_PTR =
        sampleStreamPkg::FIFO_PTR_WIDTH'(sampleStreamPkg::FIFO_DEPTH - 1);

    assign in.ready  = (count != sampleStreamPkg::FIFO_COUNT_WIDTH'(sampleStreamPkg::FIFO_DEPTH));
    assign out.valid = (count != '0);
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    // First word falls through to the output
    assign out.sample    = sampleMem[rdPtr];
    assign out.overRange = flagMem[rdPtr];

    //**************************************************
    // Storage
    //**************************************************
    always_ff @(posedge clk) begin
        if (push) begin
            sampleMem[wrPtr] <= in.sample;
            flagMem[wrPtr]   <= in.overRange;
        end
    end

    //**************************************************
    // Pointers and occupancy
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dacFormatter.sv ====
`default_nettype none

module dacFormatter (
    input  wire logic                                   clk,
    input  wire logic                                   rstN,
    sampleStreamIf.sink                                 in,
    dacControlIf.user                                   ctrl,
    output logic [sampleStreamPkg::DAC_WIDTH-1:0]       dac0Data,
    output logic [sampleStreamPkg::DAC_WIDTH-1:0]       dac1Data,
    output logic                                        dacStrobe,
    output logic                                        overRangeLed
);

    logic [busMapPkg::BUS_DATA_WIDTH-1:0] periodCount;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] periodLast;
    logic                                 slot;
    logic                                 accept;

    // Pick the channel source, then build the offset binary DAC word
    function automatic logic [sampleStreamPkg::DAC_WIDTH-1:0] dacWord(
        input sampleStreamPkg::dacSource_t           src,
        input sampleStreamPkg::sample_t              liveSample,
        input logic [busMapPkg::BUS_DATA_WIDTH-1:0] test
    );
        sampleStreamPkg::sample_t chosen;
        case (src)
            sampleStreamPkg::SRC_ADC:  chosen = liveSample;
            sampleStreamPkg::SRC_TEST: chosen = $signed({test, 2'b00});
            sampleStreamPkg::SRC_MUTE: chosen = '0;
            default:                   chosen = '0;  // Code 3 mutes too
        endcase
        return {~chosen[sampleStreamPkg::SAMPLE_WIDTH-1],
                chosen[sampleStreamPkg::SAMPLE_WIDTH-2:sampleStreamPkg::SAMPLE_PAD]};
    endfunction

    //**************************************************
    // Output pacing
    //**************************************************
    assign periodLast = (ctrl.samplePeriod == '0) ? '0 : ctrl.samplePeriod - 1'b1;
    assign slot       = (periodCount >= periodLast);  // Also catches a shortened period
    assign in.ready   = slot;
    assign accept     = in.valid && slot;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            periodCount <= '0;
        end else begin
            periodCount <= slot ? '0 : periodCount + 1'b1;
        end
    end

    //**************************************************
    // DAC words
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dac0Data     <= sampleStreamPkg::DAC_MID_SCALE;
            dac1Data     <= sampleStreamPkg::DAC_MID_SCALE;
            dacStrobe    <= 1'b0;
            overRangeLed <= 1'b0;
        end else begin
            dacStrobe <= accept;
            if (accept) begin
                dac0Data     <= dacWord(ctrl.dac0Source, in.sample, ctrl.testValue);
                dac1Data     <= dacWord(ctrl.dac1Source, in.sample, ctrl.testValue);
                overRangeLed <= in.overRange;  // Flag of the last accepted sample
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/controlRegs.sv ====
`default_nettype none

module controlRegs (
    input  wire logic                                 clk,
    input  wire logic                                 rstN,
    input  wire logic                                 busCs,
    input  wire logic                                 busWr,
    input  wire logic [busMapPkg::BUS_ADDR_WIDTH-1:0] busAddr,
    input  wire logic [busMapPkg::BUS_DATA_WIDTH-1:0] busWrData,
    output logic      [busMapPkg::BUS_DATA_WIDTH-1:0] busRdData,
    input  wire logic [busMapPkg::BUS_DATA_WIDTH-1:0] dropCount,
    dacControlIf.regs                                 ctrl
);

    sampleStreamPkg::dacSource_t           dac0Source;
    sampleStreamPkg::dacSource_t           dac1Source;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] testValue;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] samplePeriod;
    logic [busMapPkg::BUS_DATA_WIDTH-1:0] rdMux;

    //**************************************************
    // Write decode
    //**************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dac0Source   <= sampleStreamPkg::SRC_ADC;
            dac1Source   <= sampleStreamPkg::SRC_ADC;
            testValue    <= '0;
            samplePeriod <= 16'd1;
        end else if (busCs && busWr) begin
            case (busAddr)
                busMapPkg::ADDR_DAC0_SOURCE:   dac0Source   <= busWrData[1:0];
                busMapPkg::ADDR_DAC1_SOURCE:   dac1Source   <= busWrData[1:0];
                busMapPkg::ADDR_TEST_VALUE:    testValue    <= busWrData;
                busMapPkg::ADDR_SAMPLE_PERIOD: samplePeriod <= busWrData;
                default: ;  // Read only or unmapped
            endcase
        end
    end

    assign ctrl.dac0Source   = dac0Source;
    assign ctrl.dac1Source   = dac1Source;
    assign ctrl.testValue    = testValue;
    assign ctrl.samplePeriod = samplePeriod;

    //**************************************************
    // Read mux
    //**************************************************
    always_comb begin
        rdMux = '0;  // Unmapped reads as zero
        case (busAddr)
            busMapPkg::ADDR_VERSION:       rdMux      = busMapPkg::VERSION_NUMBER;
            busMapPkg::ADDR_DAC0_SOURCE:   rdMux[1:0] = dac0Source;
            busMapPkg::ADDR_DAC1_SOURCE:   rdMux[1:0] = dac1Source;
            busMapPkg::ADDR_TEST_VALUE:    rdMux      = testValue;
            busMapPkg::ADDR_SAMPLE_PERIOD: rdMux      = samplePeriod;
            busMapPkg::ADDR_DROP_COUNT:    rdMux      = dropCount;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busRdData <= '0;
        end else if (busCs && !busWr) begin
            busRdData <= rdMux;  // Valid the cycle after the read
        end
    end

endmodule

`default_nettype wire

// ==== logic/stcDacTop.sv ====
`default_nettype none

module stcDacTop (
    input  wire logic                                   clk,
    input  wire logic                                   rstN,

    // ADC
    input  wire logic [sampleStreamPkg::ADC_WIDTH-1:0] adc,
    input  wire logic                                   adcOverflow,
    input  wire logic                                   adcEn,

    // Register bus
    input  wire logic                                   busCs,
    input  wire logic                                   busWr,
    input  wire logic [busMapPkg::BUS_ADDR_WIDTH-1:0]  busAddr,
    input  wire logic [busMapPkg::BUS_DATA_WIDTH-1:0]  busWrData,
    output logic      [busMapPkg::BUS_DATA_WIDTH-1:0]  busRdData,

    // DAC
    output logic      [sampleStreamPkg::DAC_WIDTH-1:0] dac0Data,
    output logic      [sampleStreamPkg::DAC_WIDTH-1:0] dac1Data,
    output logic                                        dacStrobe,

    output logic                                        overRangeLed
);

    logic [busMapPkg::BUS_DATA_WIDTH-1:0] dropCount;

    sampleStreamIf captureStream ();  // Capture to buffer
    sampleStreamIf bufferStream ();   // Buffer to formatter
    dacControlIf   dacCtrl ();

    //**************************************************
    // Sample path
    //**************************************************
    adcCapture adcCapture (
        .clk         (clk),
        .rstN        (rstN),
        .adc         (adc),
        .adcOverflow (adcOverflow),
        .adcEn       (adcEn),
        .out         (captureStream),
        .dropCount   (dropCount)
    );

    sampleFifo sampleFifo (
        .clk  (clk),
        .rstN (rstN),
        .in   (captureStream),
        .out  (bufferStream)
    );

    dacFormatter dacFormatter (
        .clk          (clk),
        .rstN         (rstN),
        .in           (bufferStream),
        .ctrl         (dacCtrl),
        .dac0Data     (dac0Data),
        .dac1Data     (dac1Data),
        .dacStrobe    (dacStrobe),
        .overRangeLed (overRangeLed)
    );

    //**************************************************
    // Registers
    //**************************************************
    controlRegs controlRegs (
        .clk       (clk),
        .rstN      (rstN),
        .busCs     (busCs),
        .busWr     (busWr),
        .busAddr   (busAddr),
        .busWrData (busWrData),
        .busRdData (busRdData),
        .dropCount (dropCount),
        .ctrl      (dacCtrl)
    );

endmodule

`default_nettype wire

// ==== verif/stcDacChecker.sv ====
`default_nettype none

module stcDacChecker (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic [13:0] adc,
    input  wire logic        adcOverflow,
    input  wire logic        adcEn,
    input  wire logic        busCs,
    input  wire logic        busWr,
    input  wire logic [3:0]  busAddr,
    input  wire logic [15:0] busWrData,
    input  wire logic [15:0] busRdData,
    input  wire logic [13:0] dac0Data,
    input  wire logic [13:0] dac1Data,
    input  wire logic        dacStrobe,
    input  wire logic        overRangeLed,
    input  wire logic [3:0]  testId,
    output int               errorCount,
    output int               checkCount
);

    localparam logic [3:0] RESET_TEST = 4'd1;
    localparam logic [3:0] BURST_TEST = 4'd4;  // Drops allowed here

    logic [14:0] captureQ [$];  // {flag, adc word}
    logic [1:0]  dac0Src;
    logic [1:0]  dac1Src;
    logic [15:0] testValue;
    logic [15:0] samplePeriod;
    logic        readPending;
    logic [3:0]  readAddr;
    logic [15:0] readExpect;
    logic [3:0]  lastTest;
    int          burstSent;
    int          burstStrobes;
    int          testChecks;
    int          testErrors;

    function automatic string testName(input logic [3:0] id);
        case (id)
            4'd1:    return "reset state";
            4'd2:    return "pass-through";
            4'd3:    return "source select";
            4'd4:    return "back-pressure";
            4'd5:    return "over-range";
            4'd6:    return "register readback";
            default: return "idle";
        endcase
    endfunction

    // DAC word the rules give for one channel
    function automatic logic [13:0] dacWordFor(input logic [1:0] src, input logic [13:0] word);
        case (src)
            2'd0:    return word;  // Offset binary in, offset binary out
            2'd1:    return {~testValue[15], testValue[14:2]};
            default: return 14'd8192;
        endcase
    endfunction

    function automatic logic [15:0] registerValue(input logic [3:0] addr);
        case (addr)
            4'd0:    return 16'd624;
            4'd1:    return {14'd0, dac0Src};
            4'd2:    return {14'd0, dac1Src};
            4'd3:    return testValue;
            4'd4:    return samplePeriod;
            4'd5:    return 16'(burstSent - burstStrobes);  // Sent minus delivered
            default: return 16'd0;
        endcase
    endfunction

    task automatic compareValue(input string what, input logic [15:0] expected,
                                input logic [15:0] actual);
        checkCount++;
        testChecks++;
        if (expected !== actual) begin
            errorCount++;
            testErrors++;
            $display("Fail %s: %s expected %0d, actual %0d",
                     testName(lastTest), what, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        testErrors++;
        $display("Error in %s: %s", testName(lastTest), what);
    endtask

    task automatic closeTest();
        if (lastTest >= 4'd1 && lastTest <= 4'd6) begin
            if (lastTest != BURST_TEST && captureQ.size() != 0) begin
                reportProblem($sformatf("%0d captured samples never reached the DAC",
                                        captureQ.size()));
            end
            $display("Test %0d %s: %0d checks, %0d errors",
                     lastTest, testName(lastTest), testChecks, testErrors);
        end
        captureQ.delete();
        testChecks = 0;
        testErrors = 0;
    endtask

    //**************************************************
    // Model and comparisons at the rising edge
    //**************************************************
    always @(posedge clk) begin
        logic [14:0] expected;
        if (!rstN) begin
            dac0Src      = 2'd0;
            dac1Src      = 2'd0;
            testValue    = 16'd0;
            samplePeriod = 16'd1;
            readPending  = 1'b0;
            lastTest     = testId;
        end else begin
            if (testId != lastTest) begin
                closeTest();
                lastTest = testId;
            end
            if (readPending) begin
                compareValue($sformatf("read of register %0d", readAddr), readExpect, busRdData);
                readPending = 1'b0;
            end
            if (busCs && !busWr) begin
                readPending = 1'b1;
                readAddr    = busAddr;
                readExpect  = registerValue(busAddr);
            end
            if (busCs && busWr) begin
                case (busAddr)
                    4'd1:    dac0Src      = busWrData[1:0];
                    4'd2:    dac1Src      = busWrData[1:0];
                    4'd3:    testValue    = busWrData;
                    4'd4:    samplePeriod = busWrData;
                    default: ;
                endcase
            end
            if (adcEn) begin
                captureQ.push_back({adcOverflow, adc});
                if (testId == BURST_TEST) begin
                    burstSent++;
                end
            end
            if (testId == RESET_TEST) begin  // Quiet outputs at mid-scale
                compareValue("dacStrobe", 16'd0, 16'(dacStrobe));
                compareValue("idle dac0Data", 16'd8192, 16'(dac0Data));
                compareValue("idle dac1Data", 16'd8192, 16'(dac1Data));
            end
            if (dacStrobe) begin
                if (testId == BURST_TEST) begin
                    burstStrobes++;
                end
                if (captureQ.size() == 0) begin
                    reportProblem("DAC strobe with no captured sample waiting");
                end else begin
                    if (testId == BURST_TEST) begin
                        // Skip words the full buffer threw away
                        expected = captureQ[0];
                        while (captureQ.size() > 1 && expected[13:0] != dac0Data) begin
                            void'(captureQ.pop_front());
                            expected = captureQ[0];
                        end
                    end
                    expected = captureQ.pop_front();
                    compareValue("dac0Data", 16'(dacWordFor(dac0Src, expected[13:0])),
                                 16'(dac0Data));
                    compareValue("dac1Data", 16'(dacWordFor(dac1Src, expected[13:0])),
                                 16'(dac1Data));
                    compareValue("overRangeLed", 16'(expected[14]), 16'(overRangeLed));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/stcDacTb.sv ====
`default_nettype none

module stcDacTb;

    localparam int PASS_SAMPLES   = 200;
    localparam int SELECT_SAMPLES = 60;
    localparam int BURST_SAMPLES  = 100;
    localparam int FLAG_SAMPLES   = 50;
    localparam int MAX_PERIOD     = 20;
    localparam int CYCLE_LIMIT    =
        (PASS_SAMPLES + SELECT_SAMPLES + BURST_SAMPLES + FLAG_SAMPLES) * MAX_PERIOD + 2000;

    logic        clk;
    logic        rstN;
    logic [13:0] adc;
    logic        adcOverflow;
    logic        adcEn;
    logic        busCs;
    logic        busWr;
    logic [3:0]  busAddr;
    logic [15:0] busWrData;
    logic [15:0] busRdData;
    logic [13:0] dac0Data;
    logic [13:0] dac1Data;
    logic        dacStrobe;
    logic        overRangeLed;
    logic [3:0]  testId;
    int          errorCount;
    int          checkCount;
    int          cycles;
    integer      seed = 66;

    stcDacTop dut (
        .clk          (clk),
        .rstN         (rstN),
        .adc          (adc),
        .adcOverflow  (adcOverflow),
        .adcEn        (adcEn),
        .busCs        (busCs),
        .busWr        (busWr),
        .busAddr      (busAddr),
        .busWrData    (busWrData),
        .busRdData    (busRdData),
        .dac0Data     (dac0Data),
        .dac1Data     (dac1Data),
        .dacStrobe    (dacStrobe),
        .overRangeLed (overRangeLed)
    );

    stcDacChecker scoreboard (
        .clk          (clk),
        .rstN         (rstN),
        .adc          (adc),
        .adcOverflow  (adcOverflow),
        .adcEn        (adcEn),
        .busCs        (busCs),
        .busWr        (busWr),
        .busAddr      (busAddr),
        .busWrData    (busWrData),
        .busRdData    (busRdData),
        .dac0Data     (dac0Data),
        .dac1Data     (dac1Data),
        .dacStrobe    (dacStrobe),
        .overRangeLed (overRangeLed),
        .testId       (testId),
        .errorCount   (errorCount),
        .checkCount   (checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ADC pulses with a random number of idle cycles between them
    task automatic sendSamples(input int count, input int minGap, input int maxGap);
        int gap;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            adcEn       = 1'b1;
            adc         = 14'($random(seed));
            adcOverflow = 1'($random(seed));
            gap = minGap + (($random(seed) & 32'h7fff_ffff) % (maxGap - minGap + 1));
            repeat (gap) begin
                @(negedge clk);
                adcEn = 1'b0;
                adc   = 14'($random(seed));  // Ignored while adcEn is low
            end
        end
        @(negedge clk);
        adcEn = 1'b0;
    endtask

    // Done once no strobe shows up for a full slot plus the capture pipeline
    task automatic waitDrain(input int period);
        int quiet;
        quiet = 0;
        while (quiet < period + 4) begin
            @(negedge clk);
            quiet = dacStrobe ? 0 : quiet + 1;
        end
    endtask

    task automatic busWrite(input logic [3:0] addr, input logic [15:0] data);
        @(negedge clk);
        busCs     = 1'b1;
        busWr     = 1'b1;
        busAddr   = addr;
        busWrData = data;
        @(negedge clk);
        busCs = 1'b0;
        busWr = 1'b0;
    endtask

    task automatic busRead(input logic [3:0] addr);
        @(negedge clk);
        busCs   = 1'b1;
        busWr   = 1'b0;
        busAddr = addr;
        @(negedge clk);
        busCs = 1'b0;
        @(negedge clk);  // Data lands at the edge in between
    endtask

    //**************************************************
    // Test sequence
    //**************************************************
    initial begin
        rstN        = 1'b0;
        adc         = '0;
        adcOverflow = 1'b0;
        adcEn       = 1'b0;
        busCs       = 1'b0;
        busWr       = 1'b0;
        busAddr     = '0;
        busWrData   = '0;
        testId      = 4'd0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;

        testId = 4'd1;
        repeat (20) @(negedge clk);  // Observation window with no input
        busRead(4'd0);

        testId = 4'd2;
        sendSamples(PASS_SAMPLES, 1, 3);
        waitDrain(1);
        busRead(4'd5);

        testId = 4'd3;
        busWrite(4'd3, 16'($random(seed)));
        busWrite(4'd1, 16'd1);
        busWrite(4'd2, 16'd2 + 16'($random(seed) & 1));  // Codes 2 and 3 both mute
        sendSamples(SELECT_SAMPLES, 1, 2);
        waitDrain(1);

        testId = 4'd4;
        busWrite(4'd1, 16'd0);
        busWrite(4'd2, 16'd0);
        busWrite(4'd4, 16'(MAX_PERIOD));
        sendSamples(BURST_SAMPLES, 0, 0);
        waitDrain(MAX_PERIOD);
        busRead(4'd5);

        testId = 4'd5;
        busWrite(4'd4, 16'd2);
        sendSamples(FLAG_SAMPLES, 1, 1);
        waitDrain(2);

        testId = 4'd6;
        for (int addr = 1; addr <= 4; addr++) begin
            busWrite(4'(addr), 16'($random(seed)));
            busRead(4'(addr));
        end
        for (int addr = 6; addr <= 15; addr++) begin
            busWrite(4'(addr), 16'($random(seed)));
            busRead(4'(addr));
        end

        testId = 4'd7;
        repeat (2) @(negedge clk);
        $display("Summary: 6 tests, %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/busMapPkg.sv
logic/sampleStreamPkg.sv
logic/sampleStreamIf.sv
logic/dacControlIf.sv
logic/adcCapture.sv
logic/sampleFifo.sv
logic/dacFormatter.sv
logic/controlRegs.sv
logic/stcDacTop.sv
verif/stcDacChecker.sv
verif/stcDacTb.sv

// ==== Makefile ====
RTL_FILES = $(shell grep '^logic/' project.f)

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module stcDacTop $(RTL_FILES)

sim:
	verilator --binary --timing --top-module stcDacTb -f project.f -Mdir obj_dir -o stcDacSim
	./obj_dir/stcDacSim | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
